// File: logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Word and address widths
`define CPU_DATA_W    16
`define CPU_ADDR_W    8

// General registers gr0 .. gr7
`define CPU_NUM_GR    8

`define CPU_MEM_WORDS 256

// Opcode field at the top of each instruction
`define CPU_OP_W      5

`endif

// File: logic/cpu_isa_pkg.sv
`default_nettype none
`include "cpu_config.svh"

package cpu_isa_pkg;

    typedef logic [$clog2(`CPU_NUM_GR)-1:0] gr_idx_t;

    // Formats
    //   reg ops    {op, r1, 0, r2, 0, r3}
    //   load/store {op, r1, 0, r2, off4}
    //   ADDI       {op, r1, imm8}
    //   CMP        {op, 0000, r2, 0, r3}
    //   branches   {op, r1, target8}
    typedef enum logic [`CPU_OP_W-1:0] {
        OP_NOP   = 5'b00000,
        OP_HALT  = 5'b00001,
        OP_LOAD  = 5'b00010,
        OP_STORE = 5'b00011,
        OP_ADD   = 5'b01000,
        OP_ADDI  = 5'b01001,
        OP_SUB   = 5'b01010,
        OP_CMP   = 5'b01100,
        OP_AND   = 5'b01101,
        OP_OR    = 5'b01110,
        OP_JUMP  = 5'b11000,
        OP_BZ    = 5'b11010,    // r1 = gr0 tests the zero flag
        OP_BNZ   = 5'b11011
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        RUN       = 2'd1,
        LOAD_WAIT = 2'd2,   // Load data on the bus, fetch held
        HALTED    = 2'd3
    } core_state_e;

endpackage

`default_nettype wire

// File: logic/cpu_bus_pkg.sv
`default_nettype none
`include "cpu_config.svh"

package cpu_bus_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // Listed in priority order, highest first
    typedef enum logic [1:0] {
        HOST  = 2'd0,
        DATA  = 2'd1,
        FETCH = 2'd2
    } requester_e;

endpackage

`default_nettype wire

// File: logic/unified_ram.sv
`default_nettype none
`include "cpu_config.svh"

module unified_ram (
    input  wire                     clk,
    input  wire                     i_we,
    input  wire cpu_bus_pkg::addr_t i_addr,
    input  wire cpu_bus_pkg::word_t i_wdata,
    output cpu_bus_pkg::word_t      o_rdata
);

    import cpu_bus_pkg::*;

    // Survives reset so a program can be loaded before start
    word_t mem [`CPU_MEM_WORDS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];    // Old word on a write
    end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`default_nettype none
`include "cpu_config.svh"

module mem_arbiter (
    input  wire                     clk,
    input  wire                     i_reset,
    input  wire                     i_host_req,
    input  wire                     i_host_we,
    input  wire cpu_bus_pkg::addr_t i_host_addr,
    input  wire cpu_bus_pkg::word_t i_host_wdata,
    input  wire                     i_data_req,
    input  wire                     i_data_we,
    input  wire cpu_bus_pkg::addr_t i_data_addr,
    input  wire cpu_bus_pkg::word_t i_data_wdata,
    input  wire                     i_fetch_req,
    input  wire cpu_bus_pkg::addr_t i_fetch_addr,
    output logic                    o_fetch_grant,
    output logic                    o_ram_we,
    output cpu_bus_pkg::addr_t      o_ram_addr,
    output cpu_bus_pkg::word_t      o_ram_wdata,
    input  wire cpu_bus_pkg::word_t i_ram_rdata,
    output cpu_bus_pkg::word_t      o_host_rdata,
    output logic                    o_host_valid,
    output cpu_bus_pkg::word_t      o_data_rdata,
    output cpu_bus_pkg::word_t      o_fetch_rdata,
    output logic                    o_fetch_valid
);

    import cpu_bus_pkg::*;

    requester_e owner;
    requester_e owner_q;   // Who gets the word coming back
    logic       any_req;
    logic       rd_q;      // Last cycle was a read

    always_comb begin
        owner = FETCH;
        if (i_host_req) begin
            owner = HOST;
        end else if (i_data_req) begin
            owner = DATA;
        end
    end

    assign any_req       = i_host_req | i_data_req | i_fetch_req;
    assign o_fetch_grant = i_fetch_req & ~i_host_req & ~i_data_req;

    always_comb begin
        case (owner)
            HOST: begin
                o_ram_we    = i_host_we;
                o_ram_addr  = i_host_addr;
                o_ram_wdata = i_host_wdata;
            end
            DATA: begin
                o_ram_we    = i_data_we;
                o_ram_addr  = i_data_addr;
                o_ram_wdata = i_data_wdata;
            end
            default: begin
                o_ram_we    = 1'b0;            // Fetch only reads
                o_ram_addr  = i_fetch_addr;
                o_ram_wdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            owner_q <= FETCH;
            rd_q    <= 1'b0;
        end else begin
            owner_q <= owner;
            rd_q    <= any_req & ~o_ram_we;
        end
    end

    assign o_host_valid  = rd_q & (owner_q == HOST);
    assign o_host_rdata  = o_host_valid ? i_ram_rdata : '0;
    assign o_data_rdata  = (owner_q == DATA) ? i_ram_rdata : '0;   // Fixed latency, no strobe
    assign o_fetch_valid = rd_q & (owner_q == FETCH);
    assign o_fetch_rdata = i_ram_rdata;

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`default_nettype none
`include "cpu_config.svh"

module fetch_unit (
    input  wire                     clk,
    input  wire                     i_reset,
    input  wire                     i_start,
    input  wire                     i_stall,
    input  wire                     i_redirect,
    input  wire cpu_bus_pkg::addr_t i_target,
    input  wire                     i_halt,
    output logic                    o_fetch_req,
    output cpu_bus_pkg::addr_t      o_fetch_addr,
    input  wire                     i_fetch_grant,
    input  wire cpu_bus_pkg::word_t i_fetch_rdata,
    input  wire                     i_fetch_valid,
    output cpu_bus_pkg::word_t      o_instr,
    output logic                    o_instr_valid,
    output cpu_bus_pkg::addr_t      o_instr_pc
);

    import cpu_bus_pkg::*;

    logic  running;
    addr_t pc;
    addr_t flight_pc;     // Address of the word on its way back
    logic  drop;          // Word in flight belongs to the old path
    logic  new_word;
    logic  hold_valid;
    word_t hold_instr;
    addr_t hold_pc;

    assign o_fetch_req  = running & ~i_stall;
    assign o_fetch_addr = pc;
    assign new_word     = i_fetch_valid & ~drop;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            running    <= 1'b0;
            pc         <= '0;
            drop       <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            drop <= (i_redirect | i_halt) & i_fetch_grant;
            if (i_start && !running) begin
                running    <= 1'b1;
                pc         <= '0;
                hold_valid <= 1'b0;
            end else begin
                if (i_halt) begin
                    running <= 1'b0;
                end
                if (i_redirect) begin
                    pc <= i_target;
                end else if (i_fetch_grant) begin
                    pc <= pc + 1'b1;
                end
                // Keep a word that lands during a load wait
                if (i_stall) begin
                    hold_valid <= hold_valid | new_word;
                end else begin
                    hold_valid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetch_grant) begin
            flight_pc <= pc;
        end
        if (new_word && i_stall && !hold_valid) begin
            hold_instr <= i_fetch_rdata;
            hold_pc    <= flight_pc;
        end
    end

    assign o_instr       = hold_valid ? hold_instr : i_fetch_rdata;
    assign o_instr_pc    = hold_valid ? hold_pc : flight_pc;
    assign o_instr_valid = (hold_valid | new_word) & ~i_stall & running;

endmodule

`default_nettype wire

// File: logic/exec_core.sv
`default_nettype none
`include "cpu_config.svh"

module exec_core (
    input  wire                     clk,
    input  wire                     i_reset,
    input  wire                     i_start,
    input  wire cpu_bus_pkg::word_t i_instr,
    input  wire                     i_instr_valid,
    output logic                    o_stall,
    output logic                    o_redirect,
    output cpu_bus_pkg::addr_t      o_target,
    output logic                    o_halt,
    output logic                    o_data_req,
    output logic                    o_data_we,
    output cpu_bus_pkg::addr_t      o_data_addr,
    output cpu_bus_pkg::word_t      o_data_wdata,
    input  wire cpu_bus_pkg::word_t i_data_rdata,
    output logic                    o_running,
    output logic                    o_halted
);

    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    core_state_e state;
    word_t       gr [`CPU_NUM_GR];
    logic        zf;
    logic        nf;
    logic        cf;

    opcode_e     op;
    gr_idx_t     r1;
    gr_idx_t     r2;
    gr_idx_t     r3;
    word_t       a1;
    word_t       a2;
    word_t       a3;
    logic [3:0]  offset;
    addr_t       field8;       // Immediate or branch target
    logic        issue;
    logic [`CPU_DATA_W:0] alu;   // Carry in the top bit
    logic        alu_op;
    logic        wr_en;
    logic        zero_cond;
    logic        taken;
    gr_idx_t     ld_dst;

    assign op     = opcode_e'(i_instr[`CPU_DATA_W-1 -: `CPU_OP_W]);
    assign r1     = i_instr[10:8];
    assign r2     = i_instr[6:4];
    assign r3     = i_instr[2:0];
    assign offset = i_instr[3:0];
    assign field8 = i_instr[`CPU_ADDR_W-1:0];

    // gr0 is never written, so it reads zero
    assign a1 = gr[r1];
    assign a2 = gr[r2];
    assign a3 = gr[r3];

    assign issue = i_instr_valid & (state == RUN);

    always_comb begin
        alu    = '0;
        alu_op = 1'b1;
        wr_en  = 1'b1;
        case (op)
            OP_ADD:  alu = {1'b0, a2} + {1'b0, a3};
            OP_ADDI: alu = {1'b0, a1} + {{(`CPU_DATA_W - `CPU_ADDR_W + 1){1'b0}}, field8};
            OP_SUB:  alu = {1'b0, a2} - {1'b0, a3};    // Carry is the borrow
            OP_CMP: begin
                alu   = {1'b0, a2} - {1'b0, a3};
                wr_en = 1'b0;
            end
            OP_AND:  alu = {1'b0, a2 & a3};
            OP_OR:   alu = {1'b0, a2 | a3};
            default: begin
                alu_op = 1'b0;
                wr_en  = 1'b0;
            end
        endcase
    end

    // Field gr0 would always branch, so it selects the zero flag instead
    assign zero_cond = (r1 == '0) ? zf : (a1 == '0);

    always_comb begin
        case (op)
            OP_JUMP: taken = 1'b1;
            OP_BZ:   taken = zero_cond;
            OP_BNZ:  taken = ~zero_cond;
            default: taken = 1'b0;
        endcase
    end

    assign o_redirect   = issue & taken;
    assign o_target     = field8;
    assign o_halt       = issue & (op == OP_HALT);
    assign o_data_req   = issue & ((op == OP_LOAD) | (op == OP_STORE));
    assign o_data_we    = issue & (op == OP_STORE);
    assign o_data_addr  = a2[`CPU_ADDR_W-1:0] + addr_t'(offset);
    assign o_data_wdata = a1;
    assign o_stall      = (state == LOAD_WAIT);
    assign o_running    = (state == RUN) | (state == LOAD_WAIT);
    assign o_halted     = (state == HALTED);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state  <= IDLE;
            zf     <= 1'b0;
            nf     <= 1'b0;
            cf     <= 1'b0;
            ld_dst <= '0;
            for (int i = 0; i < `CPU_NUM_GR; i++) begin
                gr[i] <= '0;
            end
        end else begin
            case (state)
                IDLE, HALTED: begin
                    if (i_start) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (issue) begin
                        if (op == OP_HALT) begin
                            state <= HALTED;
                        end else if (op == OP_LOAD) begin
                            state  <= LOAD_WAIT;
                            ld_dst <= r1;
                        end
                        if (alu_op) begin
                            zf <= (alu[`CPU_DATA_W-1:0] == '0);
                            nf <= alu[`CPU_DATA_W-1];
                            cf <= alu[`CPU_DATA_W];
                        end
                        if (wr_en && r1 != '0) begin
                            gr[r1] <= alu[`CPU_DATA_W-1:0];
                        end
                    end
                end
                LOAD_WAIT: begin
                    // Read data arrives one cycle after the request
                    if (ld_dst != '0) begin
                        gr[ld_dst] <= i_data_rdata;
                    end
                    state <= RUN;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/pipe_cpu_top.sv
`default_nettype none
`include "cpu_config.svh"

module pipe_cpu_top (
    input  wire                     clk,
    input  wire                     i_reset,
    input  wire                     i_start,
    input  wire                     i_host_req,
    input  wire                     i_host_we,
    input  wire cpu_bus_pkg::addr_t i_host_addr,
    input  wire cpu_bus_pkg::word_t i_host_wdata,
    output wire cpu_bus_pkg::word_t o_host_rdata,
    output wire                     o_host_valid,
    output wire                     o_running,
    output wire                     o_halted
);

    import cpu_bus_pkg::*;

    logic  stall;
    logic  redirect;
    addr_t target;
    logic  halt;
    word_t instr;
    logic  instr_valid;

    logic  data_req;
    logic  data_we;
    addr_t data_addr;
    word_t data_wdata;
    word_t data_rdata;

    logic  fetch_req;
    addr_t fetch_addr;
    logic  fetch_grant;
    word_t fetch_rdata;
    logic  fetch_valid;

    logic  ram_we;
    addr_t ram_addr;
    word_t ram_wdata;
    word_t ram_rdata;

    exec_core u_core (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_start      (i_start),
        .i_instr      (instr),
        .i_instr_valid(instr_valid),
        .o_stall      (stall),
        .o_redirect   (redirect),
        .o_target     (target),
        .o_halt       (halt),
        .o_data_req   (data_req),
        .o_data_we    (data_we),
        .o_data_addr  (data_addr),
        .o_data_wdata (data_wdata),
        .i_data_rdata (data_rdata),
        .o_running    (o_running),
        .o_halted     (o_halted)
    );

    fetch_unit u_fetch (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_start      (i_start),
        .i_stall      (stall),
        .i_redirect   (redirect),
        .i_target     (target),
        .i_halt       (halt),
        .o_fetch_req  (fetch_req),
        .o_fetch_addr (fetch_addr),
        .i_fetch_grant(fetch_grant),
        .i_fetch_rdata(fetch_rdata),
        .i_fetch_valid(fetch_valid),
        .o_instr      (instr),
        .o_instr_valid(instr_valid),
        .o_instr_pc   ()              // Debug only
    );

    mem_arbiter u_arb (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_host_req   (i_host_req),
        .i_host_we    (i_host_we),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .i_data_req   (data_req),
        .i_data_we    (data_we),
        .i_data_addr  (data_addr),
        .i_data_wdata (data_wdata),
        .i_fetch_req  (fetch_req),
        .i_fetch_addr (fetch_addr),
        .o_fetch_grant(fetch_grant),
        .o_ram_we     (ram_we),
        .o_ram_addr   (ram_addr),
        .o_ram_wdata  (ram_wdata),
        .i_ram_rdata  (ram_rdata),
        .o_host_rdata (o_host_rdata),
        .o_host_valid (o_host_valid),
        .o_data_rdata (data_rdata),
        .o_fetch_rdata(fetch_rdata),
        .o_fetch_valid(fetch_valid)
    );

    unified_ram u_ram (
        .clk    (clk),
        .i_we   (ram_we),
        .i_addr (ram_addr),
        .i_wdata(ram_wdata),
        .o_rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// File: test/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Architectural state of the reference machine
word_t m_mem [`CPU_MEM_WORDS];
word_t m_gr [`CPU_NUM_GR];
logic  m_zf;
logic  m_nf;
logic  m_cf;
word_t prog_q [$];

function automatic void model_reset();
    for (int i = 0; i < `CPU_NUM_GR; i++) begin
        m_gr[i] = '0;
    end
    m_zf = 1'b0;
    m_nf = 1'b0;
    m_cf = 1'b0;
endfunction

// Flags follow every ALU result, the register only when wr is set
function automatic void write_result(gr_idx_t d, logic [16:0] res, logic wr);
    m_zf = (res[15:0] == 16'h0000);
    m_nf = res[15];
    m_cf = res[16];
    if (wr && d != 3'd0) begin
        m_gr[d] = res[15:0];
    end
endfunction

// Interprets m_mem from address 0, returns 1 when HALT is reached
function automatic logic run_model(input int max_steps);
    addr_t   pc;
    word_t   ins;
    opcode_e op;
    gr_idx_t r1;
    gr_idx_t r2;
    gr_idx_t r3;
    addr_t   ea;
    logic    cond;
    logic    done;
    pc = '0;
    done = 1'b0;
    for (int s = 0; s < max_steps && !done; s++) begin
        ins = m_mem[pc];
        op  = opcode_e'(ins[15:11]);
        r1  = ins[10:8];
        r2  = ins[6:4];
        r3  = ins[2:0];
        ea  = m_gr[r2][7:0] + {4'h0, ins[3:0]};
        cond = (r1 == 3'd0) ? m_zf : (m_gr[r1] == 16'h0000);   // gr0 selects the zero flag
        pc  = pc + 8'd1;
        case (op)
            OP_HALT:  done = 1'b1;
            OP_LOAD:  begin
                if (r1 != 3'd0) begin
                    m_gr[r1] = m_mem[ea];
                end
            end
            OP_STORE: m_mem[ea] = m_gr[r1];
            OP_ADD:   write_result(r1, {1'b0, m_gr[r2]} + {1'b0, m_gr[r3]}, 1'b1);
            OP_ADDI:  write_result(r1, {1'b0, m_gr[r1]} + {9'h000, ins[7:0]}, 1'b1);
            OP_SUB:   write_result(r1, {1'b0, m_gr[r2]} - {1'b0, m_gr[r3]}, 1'b1);
            OP_CMP:   write_result(r1, {1'b0, m_gr[r2]} - {1'b0, m_gr[r3]}, 1'b0);
            OP_AND:   write_result(r1, {1'b0, m_gr[r2] & m_gr[r3]}, 1'b1);
            OP_OR:    write_result(r1, {1'b0, m_gr[r2] | m_gr[r3]}, 1'b1);
            OP_JUMP:  pc = ins[7:0];
            OP_BZ:    pc = cond ? ins[7:0] : pc;
            OP_BNZ:   pc = cond ? pc : ins[7:0];
            default:  done = 1'b0;    // Unknown codes do nothing
        endcase
    end
    return done;
endfunction

function automatic word_t reg_form(opcode_e op, gr_idx_t d, gr_idx_t a, gr_idx_t b);
    return {op, d, 1'b0, a, 1'b0, b};
endfunction

function automatic word_t mem_form(opcode_e op, gr_idx_t d, gr_idx_t base, logic [3:0] off);
    return {op, d, 1'b0, base, off};
endfunction

function automatic word_t imm_form(opcode_e op, gr_idx_t d, logic [7:0] v);
    return {op, d, v};
endfunction

function automatic void emit(word_t w);
    prog_q.push_back(w);
endfunction

function automatic void clear_reg(gr_idx_t d);
    emit(reg_form(OP_AND, d, 3'd0, 3'd0));
endfunction

// Input base in gr6, output base in gr7
function automatic void set_bases();
    clear_reg(3'd6);
    emit(imm_form(OP_ADDI, 3'd6, 8'hC0));
    clear_reg(3'd7);
    emit(imm_form(OP_ADDI, 3'd7, 8'hE0));
endfunction

`endif

// File: test/pipe_cpu_tb.sv
`default_nettype none
`include "cpu_config.svh"

module pipe_cpu_tb;

    import cpu_isa_pkg::*;
    import cpu_bus_pkg::*;

    localparam int MAX_CYCLES = 4 * 200 * 6 + 3000;

    logic  clk;
    logic  i_reset;
    logic  i_start;
    logic  i_host_req;
    logic  i_host_we;
    addr_t i_host_addr;
    word_t i_host_wdata;
    word_t o_host_rdata;
    logic  o_host_valid;
    logic  o_running;
    logic  o_halted;

    int          cycle;
    int          mismatches;
    int          others;
    logic [15:0] lfsr;
    addr_t       addr_q [$];
    word_t       exp_q [$];
    int          cyc_q [$];

    pipe_cpu_top dut_i (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_host_req  (i_host_req),
        .i_host_we   (i_host_we),
        .i_host_addr (i_host_addr),
        .i_host_wdata(i_host_wdata),
        .o_host_rdata(o_host_rdata),
        .o_host_valid(o_host_valid),
        .o_running   (o_running),
        .o_halted    (o_halted)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [7:0] rand_byte(input int n);
        logic [15:0] v;
        v = rand_bits(n);
        return v[7:0];
    endfunction

    `include "cpu_ref_model.svh"

    function automatic void build_program(input int kind);
        int   top;
        int   fix;
        int   fix2;
        logic [7:0] b;
        prog_q.delete();
        if (kind != 5) begin
            clear_reg(3'd7);
            emit(imm_form(OP_ADDI, 3'd7, 8'hE0));
        end
        case (kind)
            0: begin    // ALU ops on loaded operands
                set_bases();
                emit(mem_form(OP_LOAD, 3'd1, 3'd6, 4'd0));
                emit(mem_form(OP_LOAD, 3'd2, 3'd6, 4'd1));
                emit(reg_form(OP_ADD, 3'd3, 3'd1, 3'd2));
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd0));
                emit(reg_form(OP_SUB, 3'd3, 3'd1, 3'd2));
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd1));
                emit(reg_form(OP_AND, 3'd3, 3'd1, 3'd2));
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd2));
                emit(reg_form(OP_OR, 3'd3, 3'd1, 3'd2));
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd3));
                emit(imm_form(OP_ADDI, 3'd1, rand_byte(8)));
                emit(mem_form(OP_STORE, 3'd1, 3'd7, 4'd4));
                emit(reg_form(OP_ADD, 3'd0, 3'd1, 3'd2));
                emit(mem_form(OP_STORE, 3'd0, 3'd7, 4'd5));
                emit(imm_form(OP_ADDI, 3'd0, 8'h05));
                emit(mem_form(OP_STORE, 3'd0, 3'd7, 4'd6));
            end
            1: begin    // Loaded value used by the very next instruction
                set_bases();
                emit(mem_form(OP_LOAD, 3'd1, 3'd6, 4'd2));
                emit(reg_form(OP_ADD, 3'd3, 3'd1, 3'd1));
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd0));
                emit(mem_form(OP_LOAD, 3'd2, 3'd6, 4'd3));
                emit(mem_form(OP_STORE, 3'd2, 3'd7, 4'd1));
                emit(mem_form(OP_LOAD, 3'd4, 3'd6, 4'd4));
                emit(mem_form(OP_LOAD, 3'd5, 3'd6, 4'd5));
                emit(reg_form(OP_SUB, 3'd3, 3'd5, 3'd4));
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd2));
            end
            2: begin    // Count-down loops where each taken branch drops the next slot
                b = rand_byte(4) | 8'h01;
                clear_reg(3'd1);
                emit(imm_form(OP_ADDI, 3'd1, b));
                clear_reg(3'd2);
                clear_reg(3'd3);
                emit(imm_form(OP_ADDI, 3'd3, 8'h01));
                top = prog_q.size();
                emit(reg_form(OP_ADD, 3'd2, 3'd2, 3'd1));
                emit(reg_form(OP_SUB, 3'd1, 3'd1, 3'd3));
                emit(imm_form(OP_BNZ, 3'd1, 8'(top)));
                emit(imm_form(OP_ADDI, 3'd2, 8'h01));
                emit(mem_form(OP_STORE, 3'd2, 3'd7, 4'd0));
                fix = prog_q.size();
                emit(16'h0000);
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd1));
                prog_q[fix] = imm_form(OP_JUMP, 3'd0, 8'(prog_q.size()));
                clear_reg(3'd4);
                emit(imm_form(OP_ADDI, 3'd4, rand_byte(4)));
                clear_reg(3'd5);
                top = prog_q.size();
                fix2 = prog_q.size();
                emit(16'h0000);
                emit(reg_form(OP_ADD, 3'd5, 3'd5, 3'd4));
                emit(reg_form(OP_SUB, 3'd4, 3'd4, 3'd3));
                emit(imm_form(OP_JUMP, 3'd0, 8'(top)));
                emit(mem_form(OP_STORE, 3'd3, 3'd7, 4'd2));
                prog_q[fix2] = imm_form(OP_BZ, 3'd4, 8'(prog_q.size()));
                emit(mem_form(OP_STORE, 3'd5, 3'd7, 4'd3));
            end
            3: begin    // Zero flag from CMP and from a carrying ADD
                set_bases();
                emit(mem_form(OP_LOAD, 3'd1, 3'd6, 4'd0));
                emit(mem_form(OP_LOAD, 3'd2, 3'd6, 4'd1));
                clear_reg(3'd5);
                emit(reg_form(OP_CMP, 3'd0, 3'd1, 3'd1));
                emit(imm_form(OP_BZ, 3'd0, 8'(prog_q.size() + 2)));
                emit(imm_form(OP_ADDI, 3'd5, 8'h01));
                emit(reg_form(OP_CMP, 3'd0, 3'd1, 3'd2));
                emit(imm_form(OP_BZ, 3'd0, 8'(prog_q.size() + 2)));
                emit(imm_form(OP_ADDI, 3'd5, 8'h02));
                emit(mem_form(OP_STORE, 3'd5, 3'd7, 4'd0));
                clear_reg(3'd3);
                emit(imm_form(OP_ADDI, 3'd3, 8'h01));
                clear_reg(3'd4);
                emit(reg_form(OP_SUB, 3'd4, 3'd4, 3'd3));
                emit(reg_form(OP_ADD, 3'd4, 3'd4, 3'd3));
                emit(imm_form(OP_BZ, 3'd0, 8'(prog_q.size() + 2)));
                emit(imm_form(OP_ADDI, 3'd5, 8'h04));
                emit(mem_form(OP_STORE, 3'd5, 3'd7, 4'd1));
                emit(reg_form(OP_ADD, 3'd1, 3'd1, 3'd2));
                emit(imm_form(OP_BNZ, 3'd0, 8'(prog_q.size() + 2)));
                emit(imm_form(OP_ADDI, 3'd5, 8'h08));
                emit(mem_form(OP_STORE, 3'd5, 3'd7, 4'd2));
                emit(mem_form(OP_STORE, 3'd1, 3'd7, 4'd3));
            end
            4: begin    // Keeps gr1 across runs on purpose
                emit(mem_form(OP_LOAD, 3'd2, 3'd7, 4'd8));
                emit(imm_form(OP_ADDI, 3'd2, 8'h03));
                emit(mem_form(OP_STORE, 3'd2, 3'd7, 4'd8));
                emit(imm_form(OP_ADDI, 3'd1, rand_byte(8)));
                emit(mem_form(OP_STORE, 3'd1, 3'd7, 4'd9));
            end
            default: begin    // Relies on zeroed registers and flags
                emit(imm_form(OP_BZ, 3'd0, 8'(prog_q.size() + 2)));   // Zero flag straight from reset
                emit(imm_form(OP_ADDI, 3'd1, 8'h03));
                clear_reg(3'd7);
                emit(imm_form(OP_ADDI, 3'd7, 8'hE0));
                emit(imm_form(OP_ADDI, 3'd2, 8'h07));
                emit(imm_form(OP_ADDI, 3'd4, 8'h08 | rand_byte(3)));
                clear_reg(3'd3);
                emit(imm_form(OP_ADDI, 3'd3, 8'h01));
                top = prog_q.size();
                emit(reg_form(OP_SUB, 3'd4, 3'd4, 3'd3));
                emit(imm_form(OP_BNZ, 3'd4, 8'(top)));
                emit(mem_form(OP_STORE, 3'd1, 3'd7, 4'd0));
                emit(mem_form(OP_STORE, 3'd2, 3'd7, 4'd1));
                emit(mem_form(OP_STORE, 3'd5, 3'd7, 4'd2));
            end
        endcase
        emit(imm_form(OP_HALT, 3'd0, 8'h00));
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT never finished", cycle);
            $display("errors: mismatches=%0d other=%0d", mismatches, others + 1);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Each read must come back exactly one cycle after its request
    always @(negedge clk) begin : compare_reads
        addr_t a;
        word_t e;
        int    c;
        if (o_host_valid) begin
            if (exp_q.size() == 0) begin
                others++;
                $display("o_host_valid went high at %0t with no read outstanding", $time);
            end else begin
                a = addr_q.pop_front();
                e = exp_q.pop_front();
                c = cyc_q.pop_front();
                if (cycle != c + 1) begin
                    others++;
                    $display("Read of %02h at %0t came back %0d cycles late", a, $time,
                             cycle - c - 1);
                end
                if (o_host_rdata !== e) begin
                    mismatches++;
                    $display("MISMATCH time=%0t signal=o_host_rdata addr=%02h exp=%04h got=%04h",
                             $time, a, e, o_host_rdata);
                end
            end
        end
    end

    task automatic host_write(input addr_t a, input word_t d);
        @(negedge clk);
        i_host_req   = 1'b1;
        i_host_we    = 1'b1;
        i_host_addr  = a;
        i_host_wdata = d;
    endtask

    task automatic load_image();
        for (int i = 0; i < prog_q.size(); i++) begin
            host_write(addr_t'(i), m_mem[i]);
        end
        for (int a = 'hC0; a < 'h100; a++) begin
            host_write(addr_t'(a), m_mem[a]);
        end
        @(negedge clk);
        i_host_req = 1'b0;
        i_host_we  = 1'b0;
    endtask

    task automatic read_window();
        for (int a = 'hC0; a < 'h100; a++) begin
            @(negedge clk);
            i_host_req  = 1'b1;
            i_host_we   = 1'b0;
            i_host_addr = addr_t'(a);
            addr_q.push_back(addr_t'(a));
            exp_q.push_back(m_mem[a]);
            cyc_q.push_back(cycle);
        end
        @(negedge clk);
        i_host_req = 1'b0;
        @(negedge clk);
        if (exp_q.size() != 0) begin
            others++;
            $display("%0d host reads never got o_host_valid", exp_q.size());
            addr_q.delete();
            exp_q.delete();
            cyc_q.delete();
        end
    endtask

    task automatic start_cpu();
        @(negedge clk);
        i_start = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        if (o_running !== 1'b1) begin
            others++;
            $display("o_running not high one cycle after i_start at %0t", $time);
        end
    endtask

    task automatic wait_halt();
        while (o_halted !== 1'b1) begin
            @(negedge clk);
        end
        if (o_running !== 1'b0) begin
            others++;
            $display("o_running still high while halted at %0t", $time);
        end
    endtask

    task automatic run_and_check();
        if (!run_model(200)) begin
            others++;
            $display("Reference model did not reach HALT");
        end
        start_cpu();
        wait_halt();
        read_window();
    endtask

    task automatic prepare(input int kind);
        build_program(kind);
        for (int a = 'hC0; a < 'h100; a++) begin
            m_mem[a] = rand_bits(16);
        end
        for (int i = 0; i < prog_q.size(); i++) begin
            m_mem[i] = prog_q[i];
        end
        load_image();
    endtask

    initial begin
        cycle        = 0;
        mismatches   = 0;
        others       = 0;
        lfsr         = 16'd46180;
        i_reset      = 1'b1;
        i_start      = 1'b0;
        i_host_req   = 1'b0;
        i_host_we    = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        for (int a = 0; a < `CPU_MEM_WORDS; a++) begin
            m_mem[a] = '0;
        end
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        if (o_running !== 1'b0 || o_halted !== 1'b0 || o_host_valid !== 1'b0) begin
            others++;
            $display("Status outputs not low after reset");
        end

        for (int k = 0; k < 4; k++) begin
            prepare(k);
            run_and_check();
        end

        prepare(4);
        run_and_check();
        read_window();    // Still halted, registers kept
        run_and_check();  // Second start reruns on the kept state

        prepare(5);
        start_cpu();
        repeat (8) @(negedge clk);
        i_reset = 1'b1;
        repeat (5) @(negedge clk);
        i_reset = 1'b0;
        if (o_running !== 1'b0 || o_halted !== 1'b0) begin
            others++;
            $display("Status outputs not low after reset mid-program");
        end
        model_reset();
        load_image();
        run_and_check();

        $display("errors: mismatches=%0d other=%0d", mismatches, others);
        if (mismatches == 0 && others == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
+incdir+test
logic/cpu_isa_pkg.sv
logic/cpu_bus_pkg.sv
logic/unified_ram.sv
logic/mem_arbiter.sv
logic/fetch_unit.sv
logic/exec_core.sv
logic/pipe_cpu_top.sv
test/pipe_cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module pipe_cpu_tb -o pipe_cpu_tb
./obj_dir/pipe_cpu_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
